// File: rdp_defines.svh
// Build constants for the AFI-side DDR2 read datapath
// DQS group count, data widths and slots per AFI cycle
// Valid FIFO address width, extra flop stages and slot count
// Read latency shifter length and latency count width
// Read FIFO address width and OCT window delays
`ifndef RDP_DEFINES_SVH
`define RDP_DEFINES_SVH

// Number of read DQS groups on the interface
`define RDP_NUM_GROUPS 2
// DQ bits carried by one DQS group
`define RDP_GROUP_DQ 4
// Memory time slots per AFI cycle in half rate
`define RDP_SLOTS 4

// Valid prediction write address width
`define RDP_VFIFO_AW 3
// Extra flops between the write position and the shifter output
`define RDP_VFIFO_EXTRA 1
// Token slots per group, one per full-rate cycle of an AFI cycle
`define RDP_VFIFO_SLOTS 2

// Length of the read enable history and width of the tap index
`define RDP_MAX_LAT 16
`define RDP_LAT_W 4

// Read FIFO pointer width, depth is 8 so the pointers wrap by themselves
`define RDP_FIFO_AW 3

// OCT window bounds for a read latency of 5
`define RDP_OCT_ON 0
`define RDP_OCT_OFF 5

`endif

// File: rdp_data_pkg.sv
// Read data bus types
// One slot of one group, one group word and the whole AFI bus
// A one-bit-per-group vector for the sequencer controls
`include "rdp_defines.svh"

package rdp_data_pkg;

	// DQ bits of a single group in a single time slot
	typedef logic [`RDP_GROUP_DQ-1:0] dq_slot_t;

	// All time slots of one group, slot 0 in the low bits
	typedef logic [`RDP_SLOTS*`RDP_GROUP_DQ-1:0] group_word_t;

	// Full AFI read data bus covering every group and slot
	typedef logic [`RDP_NUM_GROUPS*`RDP_SLOTS*`RDP_GROUP_DQ-1:0] afi_data_t;

	// One flag per DQS group
	typedef logic [`RDP_NUM_GROUPS-1:0] group_vec_t;

endpackage

// File: rdp_ctrl_pkg.sv
// Sequencer tuning and control types
// Valid FIFO write address, full-rate shift state
// Latency tap index and read FIFO pointer
`include "rdp_defines.svh"

package rdp_ctrl_pkg;

	// Write address of the valid prediction shifter
	typedef logic [`RDP_VFIFO_AW-1:0] vfifo_addr_t;

	// Extra full-rate cycle applied to slot 0 of a group
	typedef enum logic
	{
		FR_SHIFT_NONE = 1'b0,
		FR_SHIFT_ONE = 1'b1
	} fr_shift_t;

	// Tap position in the read enable history
	typedef logic [`RDP_LAT_W-1:0] lat_count_t;

	// Read and write pointer of the data FIFO
	typedef logic [`RDP_FIFO_AW-1:0] fifo_addr_t;

endpackage

// File: rdp_tune_if.sv
// Tuning state bundle from the sequencer registers
// Valid FIFO write addresses and full-rate shifts per group
// Data FIFO pointer resets and the registered read latency
`include "rdp_defines.svh"

interface rdp_tune_if
	import rdp_data_pkg::*;
	import rdp_ctrl_pkg::*;
();

	// Per-group write position in the valid prediction shifters
	vfifo_addr_t [`RDP_NUM_GROUPS-1:0] vfifo_wr_addr;

	// Per-group full-rate shift of slot 0
	fr_shift_t [`RDP_NUM_GROUPS-1:0] fr_shift;

	// Active low pointer clear of each data FIFO
	group_vec_t fifo_rst_n;

	// Latency tap shared by both enable histories
	lat_count_t read_lat;

	// The register block owns every signal
	modport regs_mp (output vfifo_wr_addr, fr_shift, fifo_rst_n, read_lat);

	// Valid prediction only needs the address and the shift
	modport vfifo_mp (input vfifo_wr_addr, fr_shift);

	// Data FIFO only needs its pointer clear
	modport fifo_mp (input fifo_rst_n);

endinterface

// File: rdp_seq_regs.sv
// Sequencer tuning register block
// Holds the valid FIFO write address and full-rate shift of each group
// Registers the data FIFO resets and the read latency count
`include "rdp_defines.svh"

module rdp_seq_regs
	import rdp_data_pkg::*;
	import rdp_ctrl_pkg::*;
(
	input logic pll_afi_clk,
	input logic reset_n_afi_clk,
	input group_vec_t seq_read_fifo_reset_i,
	input lat_count_t seq_read_latency_counter_i,
	input group_vec_t seq_read_increment_vfifo_fr_i,
	input group_vec_t seq_read_increment_vfifo_hr_i,
	rdp_tune_if.regs_mp tune
);

	// ***********************************************************
	// Per-group valid prediction tuning
	// ***********************************************************

	// The sequencer steps the write address during calibration until
	// the predicted valid window lines up with the returned data
	// A full-rate request shifts slot 0 by one more full-rate cycle
	// and a following half-rate request removes that shift again
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			for (int g = 0; g < `RDP_NUM_GROUPS; g++)
			begin
				tune.vfifo_wr_addr[g] <= '0;
				tune.fr_shift[g] <= FR_SHIFT_NONE;
			end
		end
		else
		begin
			for (int g = 0; g < `RDP_NUM_GROUPS; g++)
			begin
				// Address wraps around the shifter length
				if (seq_read_increment_vfifo_hr_i[g])
					tune.vfifo_wr_addr[g] <= tune.vfifo_wr_addr[g] + vfifo_addr_t'(1);

				// Full-rate request wins over half-rate in the same cycle
				if (seq_read_increment_vfifo_fr_i[g])
					tune.fr_shift[g] <= FR_SHIFT_ONE;
				else if (seq_read_increment_vfifo_hr_i[g])
					tune.fr_shift[g] <= FR_SHIFT_NONE;
			end
		end
	end

	// ***********************************************************
	// Data FIFO resets and latency count
	// ***********************************************************

	// FIFO pointers stay cleared while the system reset is active
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			tune.fifo_rst_n <= '0;
			tune.read_lat <= '0;
		end
		else
		begin
			tune.fifo_rst_n <= ~seq_read_fifo_reset_i;
			tune.read_lat <= seq_read_latency_counter_i;
		end
	end

endmodule

// File: rdp_vfifo.sv
// Read valid prediction per DQS group
// Full-rate cycle shift of the slot 0 token
// Token shift registers written at the tuned address
// Registered slot-major DQS enable control output
`include "rdp_defines.svh"

module rdp_vfifo
	import rdp_ctrl_pkg::*;
(
	input logic pll_afi_clk,
	input logic reset_n_afi_clk,
	input logic afi_rdata_en_full_i,
	rdp_tune_if.vfifo_mp tune,
	output logic [`RDP_NUM_GROUPS*`RDP_VFIFO_SLOTS-1:0] dqs_enable_ctrl_o
);

	// Room for every write address plus the extra output stages
	localparam int SHIFT_LEN = (1 << `RDP_VFIFO_AW) + `RDP_VFIFO_EXTRA;
	localparam int POS_W = $clog2(SHIFT_LEN);

	// Previous full enable, used when slot 0 runs one full-rate cycle late
	logic en_full_q;
	// Shifter outputs before the output register, slot-major order
	logic [`RDP_NUM_GROUPS*`RDP_VFIFO_SLOTS-1:0] vfifo_out;

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
			en_full_q <= 1'b0;
		else
			en_full_q <= afi_rdata_en_full_i;
	end

	// ***********************************************************
	// Token generation and shift registers
	// ***********************************************************

	for (genvar g = 0; g < `RDP_NUM_GROUPS; g++)
	begin : group_gen
		// One token per full-rate cycle of the AFI cycle
		logic [`RDP_VFIFO_SLOTS-1:0] token;
		// Shifter position receiving this cycle's token
		logic [POS_W-1:0] wr_pos;

		// With the shift applied, slot 0 carries the token of the
		// previous AFI cycle so the burst starts one full-rate cycle later
		assign token[1] = afi_rdata_en_full_i;
		assign token[0] = (tune.fr_shift[g] == FR_SHIFT_ONE) ? en_full_q : afi_rdata_en_full_i;

		assign wr_pos = POS_W'(tune.vfifo_wr_addr[g]) + POS_W'(`RDP_VFIFO_EXTRA);

		for (genvar s = 0; s < `RDP_VFIFO_SLOTS; s++)
		begin : slot_gen
			logic [SHIFT_LEN-1:0] shifter;

			// Everything moves one place toward bit 0 each cycle and
			// the new token lands at the tuned position
			always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
			begin
				if (!reset_n_afi_clk)
				begin
					shifter <= '0;
				end
				else
				begin
					shifter <= {1'b0, shifter[SHIFT_LEN-1:1]};
					shifter[wr_pos] <= token[s];
				end
			end

			// Bit order is group plus slot times group count
			assign vfifo_out[g + s*`RDP_NUM_GROUPS] = shifter[0];
		end
	end

	// Output stage drives the DQS enable logic
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
			dqs_enable_ctrl_o <= '0;
		else
			dqs_enable_ctrl_o <= vfifo_out;
	end

endmodule

// File: rdp_latency.sv
// Read latency selection
// History shifters of the read enable and the full read enable
// Combinational FIFO read enable tap and registered AFI read valid
`include "rdp_defines.svh"

module rdp_latency
	import rdp_ctrl_pkg::*;
(
	input logic pll_afi_clk,
	input logic reset_n_afi_clk,
	input logic afi_rdata_en_i,
	input logic afi_rdata_en_full_i,
	input lat_count_t read_lat_i,
	output logic read_enable_o,
	output logic afi_rdata_valid_o
);

	// Bit n holds the enable sampled n edges before the latest one
	logic [`RDP_MAX_LAT-1:0] latency_shifter;
	logic [`RDP_MAX_LAT-1:0] full_latency_shifter;

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			latency_shifter <= '0;
			full_latency_shifter <= '0;
		end
		else
		begin
			latency_shifter <= {latency_shifter[`RDP_MAX_LAT-2:0], afi_rdata_en_i};
			full_latency_shifter <= {full_latency_shifter[`RDP_MAX_LAT-2:0], afi_rdata_en_full_i};
		end
	end

	// The FIFO reads in the cycle the tuned tap shows a full enable
	assign read_enable_o = full_latency_shifter[read_lat_i];

	// Valid lines up with the FIFO output register loaded by the same tap
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
			afi_rdata_valid_o <= 1'b0;
		else
			afi_rdata_valid_o <= latency_shifter[read_lat_i];
	end

endmodule

// File: rdp_read_fifo.sv
// Read data resynchronization FIFO
// Per-group flop memory written every AFI cycle
// Write and read pointers with per-group clear
// Output register and the slot-major and group-major orderings
`include "rdp_defines.svh"

module rdp_read_fifo
	import rdp_data_pkg::*;
	import rdp_ctrl_pkg::*;
(
	input logic pll_afi_clk,
	input logic reset_n_afi_clk,
	input afi_data_t ddio_phy_dq_i,
	input logic read_enable_i,
	rdp_tune_if.fifo_mp tune,
	output afi_data_t afi_rdata_o,
	output afi_data_t phy_mux_read_fifo_q_o
);

	localparam int GW = $bits(group_word_t);
	localparam int SW = $bits(dq_slot_t);
	localparam int DEPTH = 1 << `RDP_FIFO_AW;

	// ***********************************************************
	// Per-group storage and pointers
	// ***********************************************************

	for (genvar g = 0; g < `RDP_NUM_GROUPS; g++)
	begin : group_gen
		group_word_t mem [DEPTH];
		group_word_t wr_word;
		group_word_t rd_word;
		fifo_addr_t wr_ptr;
		fifo_addr_t rd_ptr;

		// Input bus is ordered by group, each group ordered by slot
		assign wr_word = ddio_phy_dq_i[g*GW +: GW];

		// Captured data arrives on every cycle, valid or not
		always_ff @(posedge pll_afi_clk)
		begin
			mem[wr_ptr] <= wr_word;
		end

		// The sequencer clears both pointers to realign this group
		always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
		begin
			if (!reset_n_afi_clk)
			begin
				wr_ptr <= '0;
				rd_ptr <= '0;
			end
			else if (!tune.fifo_rst_n[g])
			begin
				wr_ptr <= '0;
				rd_ptr <= '0;
			end
			else
			begin
				wr_ptr <= wr_ptr + fifo_addr_t'(1);
				if (read_enable_i)
					rd_ptr <= rd_ptr + fifo_addr_t'(1);
			end
		end

		// Output word updates on the edge where read valid rises
		always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
		begin
			if (!reset_n_afi_clk)
				rd_word <= '0;
			else if (read_enable_i)
				rd_word <= mem[rd_ptr];
		end

		// Sequencer view keeps the group-major order of the FIFO output
		assign phy_mux_read_fifo_q_o[g*GW +: GW] = rd_word;

		// AFI view is ordered by slot and sub-ordered by group
		for (genvar t = 0; t < `RDP_SLOTS; t++)
		begin : slot_gen
			dq_slot_t slot_data;

			assign slot_data = rd_word[t*SW +: SW];
			assign afi_rdata_o[(t*`RDP_NUM_GROUPS + g)*SW +: SW] = slot_data;
		end
	end

endmodule

// File: rdp_oct_ctrl.sv
// On-chip termination control
// History of the full read enable
// Termination forced off outside the read window
`include "rdp_defines.svh"

module rdp_oct_ctrl
(
	input logic pll_afi_clk,
	input logic reset_n_afi_clk,
	input logic afi_rdata_en_full_i,
	output logic force_oct_off_o
);

	// Past full enables, bit 0 is the most recent
	logic [`RDP_OCT_OFF-1:0] rdata_en_r;
	// Current enable followed by its history
	logic [`RDP_OCT_OFF:0] en_window;

	assign en_window = {rdata_en_r, afi_rdata_en_full_i};

	// Termination stays on while any enable of the window is high
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			rdata_en_r <= '0;
			force_oct_off_o <= 1'b0;
		end
		else
		begin
			rdata_en_r <= {rdata_en_r[`RDP_OCT_OFF-2:0], afi_rdata_en_full_i};
			force_oct_off_o <= ~(|en_window[`RDP_OCT_OFF:`RDP_OCT_ON]);
		end
	end

endmodule

// File: rdp_top.sv
// Top level of the AFI-clock read datapath
// Sequencer tuning registers and their interface
// Valid prediction, latency selection, data FIFO and OCT control
`include "rdp_defines.svh"

module rdp_top
	import rdp_data_pkg::*;
	import rdp_ctrl_pkg::*;
(
	input logic pll_afi_clk,
	input logic reset_n_afi_clk,
	input group_vec_t seq_read_fifo_reset_i,
	input lat_count_t seq_read_latency_counter_i,
	input group_vec_t seq_read_increment_vfifo_fr_i,
	input group_vec_t seq_read_increment_vfifo_hr_i,
	input logic afi_rdata_en_i,
	input logic afi_rdata_en_full_i,
	input afi_data_t ddio_phy_dq_i,
	output afi_data_t afi_rdata_o,
	output logic afi_rdata_valid_o,
	output afi_data_t phy_mux_read_fifo_q_o,
	output logic force_oct_off_o,
	output logic [`RDP_NUM_GROUPS*`RDP_VFIFO_SLOTS-1:0] dqs_enable_ctrl_o
);

	// FIFO read strobe from the latency tap
	logic read_enable;

	// Registered tuning state shared by the datapath blocks
	rdp_tune_if tune ();

	// ***********************************************************
	// Sequencer side
	// ***********************************************************

	rdp_seq_regs u_seq_regs (
		.pll_afi_clk (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.seq_read_fifo_reset_i (seq_read_fifo_reset_i),
		.seq_read_latency_counter_i (seq_read_latency_counter_i),
		.seq_read_increment_vfifo_fr_i (seq_read_increment_vfifo_fr_i),
		.seq_read_increment_vfifo_hr_i (seq_read_increment_vfifo_hr_i),
		.tune (tune)
	);

	// ***********************************************************
	// Datapath blocks
	// ***********************************************************

	rdp_vfifo u_vfifo (
		.pll_afi_clk (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.afi_rdata_en_full_i (afi_rdata_en_full_i),
		.tune (tune),
		.dqs_enable_ctrl_o (dqs_enable_ctrl_o)
	);

	rdp_latency u_latency (
		.pll_afi_clk (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.afi_rdata_en_i (afi_rdata_en_i),
		.afi_rdata_en_full_i (afi_rdata_en_full_i),
		.read_lat_i (tune.read_lat),
		.read_enable_o (read_enable),
		.afi_rdata_valid_o (afi_rdata_valid_o)
	);

	rdp_read_fifo u_read_fifo (
		.pll_afi_clk (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.ddio_phy_dq_i (ddio_phy_dq_i),
		.read_enable_i (read_enable),
		.tune (tune),
		.afi_rdata_o (afi_rdata_o),
		.phy_mux_read_fifo_q_o (phy_mux_read_fifo_q_o)
	);

	rdp_oct_ctrl u_oct_ctrl (
		.pll_afi_clk (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.afi_rdata_en_full_i (afi_rdata_en_full_i),
		.force_oct_off_o (force_oct_off_o)
	);

endmodule

// File: rdp_assert.sv
// Concurrent assertions bound to the read datapath top level
// Outputs held low in reset, OCT on after a full enable
// No valid rise right after a latency change
`include "rdp_defines.svh"

module rdp_assert
	import rdp_ctrl_pkg::*;
(
	input logic pll_afi_clk,
	input logic reset_n_afi_clk,
	input lat_count_t seq_read_latency_counter_i,
	input logic afi_rdata_en_full_i,
	input logic afi_rdata_valid_o,
	input logic force_oct_off_o,
	input logic [`RDP_NUM_GROUPS*`RDP_VFIFO_SLOTS-1:0] dqs_enable_ctrl_o
);

	// Second reset cycle onward, every control output is cleared
	a_reset_outputs: assert property (@(posedge pll_afi_clk)
		(!reset_n_afi_clk && $past(!reset_n_afi_clk)) |->
		(afi_rdata_valid_o == 1'b0 && force_oct_off_o == 1'b0 && dqs_enable_ctrl_o == '0))
		else $error("control outputs not cleared during reset");

	// A full enable opens the termination window on the next edge
	a_oct_on: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		afi_rdata_en_full_i |=> !force_oct_off_o)
		else $error("termination forced off right after a full enable");

	// Latency is only retuned while no read is in flight
	a_lat_static: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		$changed(seq_read_latency_counter_i) |=> !$rose(afi_rdata_valid_o))
		else $error("read valid rose just after a latency change");

endmodule

bind rdp_top rdp_assert u_rdp_assert (
	.pll_afi_clk (pll_afi_clk),
	.reset_n_afi_clk (reset_n_afi_clk),
	.seq_read_latency_counter_i (seq_read_latency_counter_i),
	.afi_rdata_en_full_i (afi_rdata_en_full_i),
	.afi_rdata_valid_o (afi_rdata_valid_o),
	.force_oct_off_o (force_oct_off_o),
	.dqs_enable_ctrl_o (dqs_enable_ctrl_o)
);

// File: tb_rdp.sv
// Testbench for the AFI-clock read datapath
// Clock, reset, stimulus phases and a watchdog
// Reference model of tuning registers, shifters, FIFO and OCT window
// Compare process and typed check tasks
`include "rdp_defines.svh"

module tb_rdp
	import rdp_data_pkg::*;
	import rdp_ctrl_pkg::*;
();

	localparam int NG = `RDP_NUM_GROUPS;
	localparam int GW = `RDP_SLOTS*`RDP_GROUP_DQ;
	localparam int SW = `RDP_GROUP_DQ;
	localparam int VSH = (1 << `RDP_VFIFO_AW) + `RDP_VFIFO_EXTRA;
	localparam int DQS_W = `RDP_NUM_GROUPS*`RDP_VFIFO_SLOTS;

	logic pll_afi_clk;
	logic reset_n_afi_clk;
	group_vec_t seq_read_fifo_reset_i;
	lat_count_t seq_read_latency_counter_i;
	group_vec_t seq_read_increment_vfifo_fr_i;
	group_vec_t seq_read_increment_vfifo_hr_i;
	logic afi_rdata_en_i;
	logic afi_rdata_en_full_i;
	afi_data_t ddio_phy_dq_i;
	afi_data_t afi_rdata_o;
	logic afi_rdata_valid_o;
	afi_data_t phy_mux_read_fifo_q_o;
	logic force_oct_off_o;
	logic [DQS_W-1:0] dqs_enable_ctrl_o;

	// Reference model state with one copy of every register in the design
	vfifo_addr_t m_addr [NG];
	fr_shift_t m_fr [NG];
	group_vec_t m_fifo_rst_n;
	lat_count_t m_lat;
	logic m_en_full_q;
	logic [VSH-1:0] m_shift [NG][2];
	logic [DQS_W-1:0] m_dqs;
	logic [`RDP_MAX_LAT-1:0] m_lat_sh;
	logic [`RDP_MAX_LAT-1:0] m_full_sh;
	logic m_valid;
	group_word_t m_mem [NG][1 << `RDP_FIFO_AW];
	fifo_addr_t m_wr_ptr [NG];
	fifo_addr_t m_rd_ptr [NG];
	group_word_t m_rd_word [NG];
	logic [`RDP_OCT_OFF-1:0] m_oct_hist;
	logic m_oct;
	logic model_ready;

	rdp_top dut (.*);

	always #2 pll_afi_clk = ~pll_afi_clk;

	// ************************************************************
	// Reference model
	// ************************************************************

	function automatic void ref_reset();
		for (int g = 0; g < NG; g++)
		begin
			m_addr[g] = '0;
			m_fr[g] = FR_SHIFT_NONE;
			m_wr_ptr[g] = '0;
			m_rd_ptr[g] = '0;
			m_rd_word[g] = '0;
			m_shift[g][0] = '0;
			m_shift[g][1] = '0;
		end
		m_fifo_rst_n = '0;
		m_lat = '0;
		m_en_full_q = 1'b0;
		m_dqs = '0;
		m_lat_sh = '0;
		m_full_sh = '0;
		m_valid = 1'b0;
		m_oct_hist = '0;
		m_oct = 1'b0;
	endfunction

	// Advances the model by one AFI edge using only the old state
	function automatic void ref_step(input logic en, input logic en_full, input afi_data_t dq,
		input group_vec_t fr_i, input group_vec_t hr_i, input group_vec_t rst_i,
		input lat_count_t lat_i);
		logic rd_en;
		logic tok;
		logic [VSH-1:0] sh;
		int pos;
		// Latency tap uses the registered latency of the previous cycle
		rd_en = m_full_sh[m_lat];
		m_valid = m_lat_sh[m_lat];
		m_lat_sh = {m_lat_sh[`RDP_MAX_LAT-2:0], en};
		m_full_sh = {m_full_sh[`RDP_MAX_LAT-2:0], en_full};
		for (int g = 0; g < NG; g++)
		begin
			for (int s = 0; s < 2; s++)
			begin
				// Slot 0 runs one full-rate cycle late under the shift
				tok = (s == 1 || m_fr[g] == FR_SHIFT_NONE) ? en_full : m_en_full_q;
				pos = int'(m_addr[g]) + `RDP_VFIFO_EXTRA;
				m_dqs[g + s*NG] = m_shift[g][s][0];
				sh = m_shift[g][s] >> 1;
				sh[pos] = tok;
				m_shift[g][s] = sh;
			end
			// Read happens before this edge's write lands
			if (rd_en)
				m_rd_word[g] = m_mem[g][m_rd_ptr[g]];
			m_mem[g][m_wr_ptr[g]] = dq[g*GW +: GW];
			if (!m_fifo_rst_n[g])
			begin
				m_wr_ptr[g] = '0;
				m_rd_ptr[g] = '0;
			end
			else
			begin
				m_wr_ptr[g] = m_wr_ptr[g] + 1'b1;
				if (rd_en)
					m_rd_ptr[g] = m_rd_ptr[g] + 1'b1;
			end
			if (hr_i[g])
				m_addr[g] = m_addr[g] + 1'b1;
			if (fr_i[g])
				m_fr[g] = FR_SHIFT_ONE;
			else if (hr_i[g])
				m_fr[g] = FR_SHIFT_NONE;
		end
		m_en_full_q = en_full;
		// Termination off when the current enable and five past ones are all low
		m_oct = ~(|{m_oct_hist, en_full});
		m_oct_hist = {m_oct_hist[`RDP_OCT_OFF-2:0], en_full};
		m_fifo_rst_n = ~rst_i;
		m_lat = lat_i;
	endfunction

	// Slot-major view of the expected FIFO output
	function automatic afi_data_t slot_major();
		afi_data_t d;
		for (int g = 0; g < NG; g++)
			for (int t = 0; t < `RDP_SLOTS; t++)
				d[(t*NG + g)*SW +: SW] = m_rd_word[g][t*SW +: SW];
		return d;
	endfunction

	function automatic afi_data_t group_major();
		afi_data_t d;
		for (int g = 0; g < NG; g++)
			d[g*GW +: GW] = m_rd_word[g];
		return d;
	endfunction

	// Inputs read here still hold their pre-edge values
	always @(posedge pll_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			ref_reset();
			model_ready = 1'b1;
		end
		else
		begin
			ref_step(afi_rdata_en_i, afi_rdata_en_full_i, ddio_phy_dq_i,
				seq_read_increment_vfifo_fr_i, seq_read_increment_vfifo_hr_i,
				seq_read_fifo_reset_i, seq_read_latency_counter_i);
		end
	end

	// ************************************************************
	// Checks
	// ************************************************************

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_data(input string what, input afi_data_t exp, input afi_data_t act);
		if (act !== exp)
			fail_run($sformatf("** Error at time %0t: %s expected %h got %h", $time, what, exp, act));
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (act !== exp)
			fail_run($sformatf("** Error at time %0t: %s expected %b got %b", $time, what, exp, act));
	endtask

	task automatic check_vec(input string what, input logic [DQS_W-1:0] exp,
		input logic [DQS_W-1:0] act);
		if (act !== exp)
			fail_run($sformatf("** Error at time %0t: %s expected %b got %b", $time, what, exp, act));
	endtask

	// Outputs are stable at the falling edge
	always @(negedge pll_afi_clk)
	begin
		if (model_ready)
		begin
			check_bit("afi_rdata_valid_o", m_valid, afi_rdata_valid_o);
			check_bit("force_oct_off_o", m_oct, force_oct_off_o);
			check_vec("dqs_enable_ctrl_o", m_dqs, dqs_enable_ctrl_o);
			check_data("afi_rdata_o", slot_major(), afi_rdata_o);
			check_data("phy_mux_read_fifo_q_o", group_major(), phy_mux_read_fifo_q_o);
		end
	end

	// ************************************************************
	// Stimulus
	// ************************************************************

	// One cycle of stimulus with fresh random read data
	task automatic drive(input logic en, input logic en_full, input group_vec_t fr,
		input group_vec_t hr, input group_vec_t rst);
		@(posedge pll_afi_clk);
		afi_rdata_en_i <= en;
		afi_rdata_en_full_i <= en_full;
		seq_read_increment_vfifo_fr_i <= fr;
		seq_read_increment_vfifo_hr_i <= hr;
		seq_read_fifo_reset_i <= rst;
		ddio_phy_dq_i <= afi_data_t'($urandom);
	endtask

	task automatic idle(input int n);
		for (int i = 0; i < n; i++)
			drive(1'b0, 1'b0, '0, '0, '0);
	endtask

	task automatic random_reads(input int n, input bit split);
		logic e;
		for (int i = 0; i < n; i++)
		begin
			e = 1'($urandom);
			drive(e, split ? 1'($urandom) : e, '0, '0, '0);
		end
	endtask

	// Counts edges from a single enable pulse until valid rises
	task automatic wait_valid(input int lat);
		int edges;
		bit seen;
		edges = 0;
		seen = 1'b0;
		drive(1'b1, 1'b1, '0, '0, '0);
		while (!seen)
		begin
			// First counted edge is the one that samples the pulse
			drive(1'b0, 1'b0, '0, '0, '0);
			edges++;
			@(negedge pll_afi_clk);
			seen = (afi_rdata_valid_o === 1'b1);
			if (!seen && edges > 40)
				fail_run("Read valid never rose after a read enable pulse");
		end
		if (edges - 1 != lat + 1)
			fail_run($sformatf("** Error at time %0t: valid after %0d edges, expected %0d",
				$time, edges - 1, lat + 1));
	endtask

	initial
	begin
		int lats [3];
		lats = '{2, 5, 9};
		void'($urandom(46));
		pll_afi_clk = 1'b0;
		reset_n_afi_clk = 1'b0;
		model_ready = 1'b0;
		seq_read_fifo_reset_i = '0;
		seq_read_latency_counter_i = '0;
		seq_read_increment_vfifo_fr_i = '0;
		seq_read_increment_vfifo_hr_i = '0;
		afi_rdata_en_i = 1'b0;
		afi_rdata_en_full_i = 1'b0;
		ddio_phy_dq_i = '0;
		repeat (8) @(posedge pll_afi_clk);
		reset_n_afi_clk <= 1'b1;
		idle(4);
		// The latency only moves while the enables are idle
		foreach (lats[i])
		begin
			seq_read_latency_counter_i <= lat_count_t'(lats[i]);
			idle(20);
			wait_valid(lats[i]);
			idle(4);
			random_reads(40, 1'b0);
			idle(20);
		end
		// Half-rate steps move each group's tokens on its own
		drive(1'b0, 1'b0, '0, 2'b01, '0);
		drive(1'b0, 1'b0, '0, 2'b01, '0);
		random_reads(30, 1'b0);
		drive(1'b0, 1'b0, '0, 2'b10, '0);
		random_reads(30, 1'b0);
		// Full-rate shift on group 1 and its clear by a half-rate step
		drive(1'b0, 1'b0, 2'b10, '0, '0);
		random_reads(30, 1'b0);
		drive(1'b0, 1'b0, '0, 2'b10, '0);
		random_reads(30, 1'b0);
		// OCT window with enables that differ from each other
		random_reads(60, 1'b1);
		// Pointer restart of group 0 only
		drive(1'b1, 1'b1, '0, '0, 2'b01);
		random_reads(40, 1'b0);
		idle(20);
		$display("ALL TESTS PASSED");
		$finish;
	end

	// Watchdog against a stuck run
	initial
	begin
		for (int i = 0; i < 20000; i++)
			@(posedge pll_afi_clk);
		fail_run("Simulation watchdog expired before the test finished");
	end

endmodule

// File: all.f
+incdir+.
rdp_data_pkg.sv
rdp_ctrl_pkg.sv
rdp_tune_if.sv
rdp_seq_regs.sv
rdp_vfifo.sv
rdp_latency.sv
rdp_read_fifo.sv
rdp_oct_ctrl.sv
rdp_top.sv
rdp_assert.sv
tb_rdp.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the read datapath testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f all.f --top-module tb_rdp -Mdir obj_dir \
	&& ./obj_dir/Vtb_rdp \
	|| exit 1
